// File: hw/nn_pkg.sv
/* frame geometry constants, sample type and counter types
   shared by the max-pool and up-sampling stages */
package nn_pkg;

    // stream sample
    localparam int DATA_WIDTH = 8;                  // bits per sample

    // frame geometry, one channel only
    localparam int LINE_LEN   = 7;                  // samples per line
    localparam int LINE_NUM   = 7;                  // lines per frame
    localparam int FRAME_LEN  = LINE_LEN * LINE_NUM; // samples per frame

    // signed sample as carried on every stream
    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    // column inside a line
    typedef logic [$clog2(LINE_LEN)-1:0] col_t;

    // row inside a frame
    typedef logic [$clog2(LINE_NUM)-1:0] row_t;

    // sample count inside a frame
    typedef logic [$clog2(FRAME_LEN)-1:0] frame_cnt_t;

    // most negative sample, seed of the running max
    localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(DATA_WIDTH-1){1'b0}}});

    // last index helpers, sized to their counters
    localparam col_t       COL_LAST   = col_t'(LINE_LEN - 1);   // eop column
    localparam row_t       ROW_LAST   = row_t'(LINE_NUM - 1);   // last line
    localparam frame_cnt_t SMPL_LAST  = frame_cnt_t'(FRAME_LEN - 1); // eof sample

endpackage

// File: hw/max_pool_frame.sv
/* framing checker and running signed maximum over one 7x7 frame,
   pooled value strobe or frame error strobe one cycle after eof */
module max_pool_frame (
    input  logic            clk,
    input  logic            rst_n_i,

    input  nn_pkg::sample_t data_i,       // input sample
    input  logic            valid_i,      // sample strobe
    input  logic            sop_i,        // first sample of a line
    input  logic            eop_i,        // last sample of a line
    input  logic            sof_i,        // first sample of a frame
    input  logic            eof_i,        // last sample of a frame

    output nn_pkg::sample_t pool_data_o,  // frame maximum
    output logic            pool_valid_o, // one cycle per good frame
    output logic            frame_err_o   // one cycle per bad frame
);

    // frame tracking state
    logic               in_frame;  // between sof and eof
    nn_pkg::frame_cnt_t cnt;       // index of next sample in frame
    nn_pkg::col_t       col;       // index of next sample in line
    logic               err;       // sticky framing violation
    nn_pkg::sample_t    run_max;   // max so far in this frame

    // per-sample decode
    logic               start;     // sof seen while waiting
    logic               take;      // sample belongs to a frame
    nn_pkg::frame_cnt_t idx_cnt;   // position of this sample in frame
    nn_pkg::col_t       idx_col;   // position of this sample in line
    logic               line_last; // this sample closes a line
    logic               bad_sop;
    logic               bad_eop;
    logic               bad_eof;
    logic               bad_sof;
    logic               bad;       // any violation on this sample
    logic               frame_bad; // violation so far incl. this sample
    logic               frame_end; // eof accepted
    nn_pkg::sample_t    seed;      // compare base
    nn_pkg::sample_t    nxt_max;   // max including this sample

    assign start     = valid_i && !in_frame && sof_i;
    assign take      = (valid_i && in_frame) || start;

    // new frame counts from zero
    assign idx_cnt   = in_frame ? cnt : '0;
    assign idx_col   = in_frame ? col : '0;
    assign line_last = (idx_col == nn_pkg::COL_LAST);

    // flags must sit exactly on their positions
    assign bad_sop   = sop_i != (idx_col == '0);
    assign bad_eop   = eop_i != line_last;
    assign bad_eof   = eof_i != (idx_cnt == nn_pkg::SMPL_LAST); // early or missing eof
    assign bad_sof   = in_frame && sof_i;                       // sof inside a frame
    assign bad       = bad_sop || bad_eop || bad_eof || bad_sof;

    assign frame_bad = (in_frame && err) || bad; // stale err ignored on start
    assign frame_end = take && eof_i;

    // signed compare, first sample of a frame always wins over the seed
    assign seed      = in_frame ? run_max : nn_pkg::SAMPLE_MIN;
    assign nxt_max   = (data_i > seed) ? data_i : seed;

    // frame position and error tracking
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            in_frame <= 1'b0;
            cnt      <= '0;
            col      <= '0;
            err      <= 1'b0;
        end else if (take) begin
            in_frame <= !eof_i;               // any eof closes the frame
            cnt      <= idx_cnt + 1'b1;       // wraps only after an error
            col      <= line_last ? '0 : idx_col + 1'b1;
            err      <= frame_bad;            // sticky until eof
        end
    end

    // running maximum
    always_ff @(posedge clk) begin
        if (take) begin
            run_max <= nxt_max;
        end
    end

    // result strobes, one cycle after the eof sample
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pool_valid_o <= 1'b0;
            frame_err_o  <= 1'b0;
        end else begin
            pool_valid_o <= frame_end && !frame_bad; // good frame
            frame_err_o  <= frame_end && frame_bad;  // malformed frame
        end
    end

    // pooled value latched with the strobe
    always_ff @(posedge clk) begin
        if (frame_end) begin
            pool_data_o <= nxt_max;
        end
    end

    // a pooled result closes a full 49-sample frame
    a_pool_full_frame : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pool_valid_o |-> $past(in_frame && (cnt == nn_pkg::SMPL_LAST))
    ) else $error("pool_valid_o without a full frame before it");

    // frames are 49 samples long, so results never come back to back
    a_pool_single : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pool_valid_o |=> !pool_valid_o
    ) else $error("pool_valid_o high on two consecutive cycles");

endmodule

// File: hw/up_sampling_frame.sv
/* up-sampler that replays one pooled value as a full 7x7 frame,
   one registered sample per cycle with regenerated sop/eop/sof/eof */
module up_sampling_frame (
    input  logic            clk,
    input  logic            rst_n_i,

    input  nn_pkg::sample_t pool_data_i,  // value to replay
    input  logic            pool_valid_i, // starts a new frame

    output nn_pkg::sample_t data_o,       // replayed sample
    output logic            valid_o,      // sample strobe
    output logic            sop_o,        // first sample of a line
    output logic            eop_o,        // last sample of a line
    output logic            sof_o,        // first sample of the frame
    output logic            eof_o         // last sample of the frame
);

    // position of the sample now on the output
    nn_pkg::col_t col;
    nn_pkg::row_t row;

    // next sample position
    nn_pkg::col_t nxt_col;
    nn_pkg::row_t nxt_row;
    logic         col_wrap;  // current sample closes a line
    logic         busy;      // more samples of this frame to send

    // the eof cycle already accepts a new value
    assign busy     = valid_o && !eof_o;

    assign col_wrap = (col == nn_pkg::COL_LAST);
    assign nxt_col  = col_wrap ? '0 : col + 1'b1;
    assign nxt_row  = col_wrap ? row + 1'b1 : row;

    // counters and framing flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            col     <= '0;
            row     <= '0;
            valid_o <= 1'b0;
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
        end else if (pool_valid_i) begin
            col     <= '0;                     // first sample of the frame
            row     <= '0;
            valid_o <= 1'b1;
            sop_o   <= 1'b1;
            eop_o   <= 1'b0;                   // lines are longer than one
            sof_o   <= 1'b1;
            eof_o   <= 1'b0;
        end else if (busy) begin
            col     <= nxt_col;
            row     <= nxt_row;
            valid_o <= 1'b1;
            sop_o   <= (nxt_col == '0);        // follows each eop
            eop_o   <= (nxt_col == nn_pkg::COL_LAST);
            sof_o   <= 1'b0;
            eof_o   <= (nxt_col == nn_pkg::COL_LAST) &&
                       (nxt_row == nn_pkg::ROW_LAST); // 49th sample
        end else begin
            valid_o <= 1'b0;                   // idle after eof
            sop_o   <= 1'b0;
            eop_o   <= 1'b0;
            sof_o   <= 1'b0;
            eof_o   <= 1'b0;
        end
    end

    // pooled value held on the data output for the whole frame
    always_ff @(posedge clk) begin
        if (pool_valid_i) begin
            data_o <= pool_data_i;
        end
    end

    // pool stage spaces results by a full frame
    a_no_overrun : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pool_valid_i |-> !busy
    ) else $error("pooled value arrived while frame replay busy");

    // every replay opens with a frame start
    a_start_sof : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(valid_o) |-> sof_o
    ) else $error("output frame started without sof_o");

endmodule

// File: hw/nn_top.sv
/* top level with the max-pool stage feeding the up-sampler */
module nn_top (
    input  logic            clk,
    input  logic            rst_n_i,

    // input stream
    input  nn_pkg::sample_t data_i,
    input  logic            valid_i,
    input  logic            sop_i,
    input  logic            eop_i,
    input  logic            sof_i,
    input  logic            eof_i,

    // output stream, replayed frame maximum
    output nn_pkg::sample_t data_o,
    output logic            valid_o,
    output logic            sop_o,
    output logic            eop_o,
    output logic            sof_o,
    output logic            eof_o,

    output logic            frame_err_o   // malformed input frame
);

    nn_pkg::sample_t pool_data;   // frame max
    logic            pool_valid;  // one strobe per good frame

    // 7x7 global max-pool with framing check
    max_pool_frame u_max_pool_frame (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .data_i       ( data_i       ),
        .valid_i      ( valid_i      ),
        .sop_i        ( sop_i        ),
        .eop_i        ( eop_i        ),
        .sof_i        ( sof_i        ),
        .eof_i        ( eof_i        ),
        .pool_data_o  ( pool_data    ),
        .pool_valid_o ( pool_valid   ),
        .frame_err_o  ( frame_err_o  )
    );

    // 1x1 back to 7x7
    up_sampling_frame u_up_sampling_frame (
        .clk          ( clk          ),
        .rst_n_i      ( rst_n_i      ),
        .pool_data_i  ( pool_data    ),
        .pool_valid_i ( pool_valid   ),
        .data_o       ( data_o       ),
        .valid_o      ( valid_o      ),
        .sop_o        ( sop_o        ),
        .eop_o        ( eop_o        ),
        .sof_o        ( sof_o        ),
        .eof_o        ( eof_o        )
    );

endmodule

// File: verif/tb_clk_gen.sv
/* testbench clock, 4 ns period, and active low reset for 3 cycles */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD_NS = 2;  // 4 ns period
    localparam int RST_CYCLES     = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);                   // release away from the sampling edge
        rst_n_o = 1'b1;
    end

endmodule

// File: verif/nn_tests.svh
/* frame drive and output check tasks, and the directed tests */
`ifndef NN_TESTS_SVH
`define NN_TESTS_SVH

// len samples of stim, one per cycle, framing per mode
task automatic send_frame(input int len, input int mode);
    int col;
    int eop_col;
    if (mode == MODE_GOOD) begin
        exp_q.push_back(frame_max());       // reference max of this frame
    end
    for (int i = 0; i < len; i++) begin
        col     = i % nn_pkg::LINE_LEN;
        eop_col = nn_pkg::LINE_LEN - 1;
        if (mode == MODE_BAD_EOP && i / nn_pkg::LINE_LEN == 1) begin
            eop_col = nn_pkg::LINE_LEN - 2; // eop one column early in line 1
        end
        @(negedge clk);
        data_i  = stim[i];
        valid_i = 1'b1;
        sof_i   = (i == 0) && (mode != MODE_NO_SOF);
        sop_i   = (col == 0);
        eop_i   = (col == eop_col);
        eof_i   = (i == len - 1);
        if (eof_i) begin
            eof_cycle = cycle;              // cycle that carries eof
        end
    end
endtask

task automatic drive_idle();
    @(negedge clk);
    data_i  = '0;
    valid_i = 1'b0;
    sop_i   = 1'b0;
    eop_i   = 1'b0;
    sof_i   = 1'b0;
    eof_i   = 1'b0;
endtask

// no output samples, error strobe only on the first cycle if expected
// first cycle is the one right after the eof sample
task automatic watch_quiet(input int cycles, input logic err_exp);
    for (int i = 0; i < cycles; i++) begin
        if (i > 0) begin
            @(negedge clk);
        end
        check_bit("frame_err_o", err_exp && (i == 0), frame_err_o);
        check_bit("valid_o", 1'b0, valid_o);
    end
endtask

// one full output frame, 49 samples of the next expected max
task automatic collect_frame();
    nn_pkg::sample_t exp_val;
    do begin
        @(negedge clk);
    end while (!valid_o);
    check_delay("first output delay", 2, cycle - eof_cycle);
    exp_val = exp_q.pop_front();
    for (int i = 0; i < nn_pkg::FRAME_LEN; i++) begin
        if (i > 0) begin
            @(negedge clk);
        end
        check_bit("valid_o", 1'b1, valid_o);
        check_sample("data_o", exp_val, data_o);
        check_bit("sof_o", i == 0, sof_o);
        check_bit("sop_o", i % nn_pkg::LINE_LEN == 0, sop_o);
        check_bit("eop_o", i % nn_pkg::LINE_LEN == nn_pkg::LINE_LEN - 1, eop_o);
        check_bit("eof_o", i == nn_pkg::FRAME_LEN - 1, eof_o);
        check_bit("frame_err_o", 1'b0, frame_err_o);
    end
endtask

// base plus a wrapped ramp
task automatic fill_ramp(input int base, input int step, input int span);
    for (int i = 0; i < nn_pkg::FRAME_LEN; i++) begin
        stim[i] = nn_pkg::sample_t'(base + (i * step) % span);
    end
endtask

task automatic send_good_frame();
    fork
        begin
            send_frame(nn_pkg::FRAME_LEN, MODE_GOOD);
            drive_idle();
        end
        collect_frame();
    join
endtask

task automatic test_single_frame();
    test_name = "single_frame";
    fill_ramp(-45, 5, 90);                  // mixed signs, peak set below
    stim[23] = nn_pkg::sample_t'(100);
    send_good_frame();
endtask

task automatic test_signed_max();
    test_name = "signed_max";
    fill_ramp(-120, 3, 100);                // all negative
    stim[30] = nn_pkg::sample_t'(-3);       // least negative
    send_good_frame();
endtask

task automatic test_back_to_back();
    test_name = "back_to_back";
    fork
        begin
            fill_ramp(-60, 7, 110);
            stim[5] = nn_pkg::sample_t'(77);
            send_frame(nn_pkg::FRAME_LEN, MODE_GOOD);
            fill_ramp(-90, 11, 80);         // lower max, no idle cycle before
            send_frame(nn_pkg::FRAME_LEN, MODE_GOOD);
            drive_idle();
        end
        begin
            collect_frame();
            collect_frame();
        end
    join
endtask

task automatic test_malformed();
    test_name = "early_eof";
    fill_ramp(-20, 9, 120);
    send_frame(40, MODE_EARLY_EOF);         // eof on sample 40
    drive_idle();
    watch_quiet(6, 1'b1);
    test_name = "bad_eop";
    send_frame(nn_pkg::FRAME_LEN, MODE_BAD_EOP);
    drive_idle();
    watch_quiet(6, 1'b1);
    test_name = "no_sof";
    send_frame(nn_pkg::FRAME_LEN, MODE_NO_SOF); // ignored while waiting for sof
    drive_idle();
    watch_quiet(6, 1'b0);
    test_name = "good_after_errors";
    fill_ramp(-70, 13, 127);
    send_good_frame();
endtask

task automatic test_latency();
    test_name = "latency";
    repeat (3) @(negedge clk);
    fill_ramp(-100, 2, 90);
    stim[nn_pkg::FRAME_LEN-1] = nn_pkg::sample_t'(127); // peak on the eof sample
    send_good_frame();
endtask

task automatic test_random_frames();
    test_name = "random_frames";
    fork
        begin
            repeat (10) begin
                for (int i = 0; i < nn_pkg::FRAME_LEN; i++) begin
                    stim[i] = rand_sample();
                end
                send_frame(nn_pkg::FRAME_LEN, MODE_GOOD);
            end
            drive_idle();
        end
        begin
            repeat (10) collect_frame();
        end
    join
endtask

`endif

// File: verif/tb_nn_top.sv
/* testbench top with the nn_top DUT, LFSR, compare tasks, watchdog
   and the test sequence */
module tb_nn_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_FRAMES    = 19;  // frames sent over all tests
    localparam int WATCHDOG_NS   = NUM_FRAMES * (2 * nn_pkg::FRAME_LEN + 10) * CLK_PERIOD_NS;
    localparam logic [31:0] LFSR_SEED = 32'hf17e;

    // framing variants of send_frame
    localparam int MODE_GOOD      = 0;
    localparam int MODE_EARLY_EOF = 1;
    localparam int MODE_BAD_EOP   = 2;
    localparam int MODE_NO_SOF    = 3;

    logic            clk;
    logic            rst_n;
    nn_pkg::sample_t data_i;
    logic            valid_i;
    logic            sop_i;
    logic            eop_i;
    logic            sof_i;
    logic            eof_i;
    nn_pkg::sample_t data_o;
    logic            valid_o;
    logic            sop_o;
    logic            eop_o;
    logic            sof_o;
    logic            eof_o;
    logic            frame_err_o;

    nn_pkg::sample_t stim [nn_pkg::FRAME_LEN];  // samples of the next frame
    nn_pkg::sample_t exp_q [$];                  // expected maxima, in order
    logic [31:0]     lfsr_state;
    string           test_name;
    int              cycle = 0;                  // rising edges since start
    int              eof_cycle;                  // cycle that carried the last eof

    tb_clk_gen u_tb_clk_gen (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    nn_top u_nn_top (
        .clk         ( clk         ),
        .rst_n_i     ( rst_n       ),
        .data_i      ( data_i      ),
        .valid_i     ( valid_i     ),
        .sop_i       ( sop_i       ),
        .eop_i       ( eop_i       ),
        .sof_i       ( sof_i       ),
        .eof_i       ( eof_i       ),
        .data_o      ( data_o      ),
        .valid_o     ( valid_o     ),
        .sop_o       ( sop_o       ),
        .eop_o       ( eop_o       ),
        .sof_o       ( sof_o       ),
        .eof_o       ( eof_o       ),
        .frame_err_o ( frame_err_o )
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_sample(input string what, input nn_pkg::sample_t exp,
                                input nn_pkg::sample_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_delay(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per sample bit
    function automatic nn_pkg::sample_t rand_sample();
        nn_pkg::sample_t v;
        v = '0;
        for (int b = 0; b < nn_pkg::DATA_WIDTH; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[nn_pkg::DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // largest signed sample of stim
    function automatic nn_pkg::sample_t frame_max();
        nn_pkg::sample_t m;
        m = stim[0];
        for (int i = 1; i < nn_pkg::FRAME_LEN; i++) begin
            if (stim[i] > m) begin
                m = stim[i];
            end
        end
        return m;
    endfunction

    `include "nn_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_run();
    end

    initial begin
        data_i     = '0;
        valid_i    = 1'b0;
        sop_i      = 1'b0;
        eop_i      = 1'b0;
        sof_i      = 1'b0;
        eof_i      = 1'b0;
        lfsr_state = LFSR_SEED;
        eof_cycle  = 0;
        test_name  = "reset";
        @(posedge rst_n);
        check_bit("valid_o", 1'b0, valid_o);        // outputs quiet after reset
        check_bit("sof_o", 1'b0, sof_o);
        check_bit("sop_o", 1'b0, sop_o);
        check_bit("eop_o", 1'b0, eop_o);
        check_bit("eof_o", 1'b0, eof_o);
        check_bit("frame_err_o", 1'b0, frame_err_o);
        test_single_frame();
        test_signed_max();
        test_back_to_back();
        test_malformed();
        test_latency();
        test_random_frames();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: nn_top.f
+incdir+verif
hw/nn_pkg.sv
hw/max_pool_frame.sv
hw/up_sampling_frame.sv
hw/nn_top.sv
verif/tb_clk_gen.sv
verif/tb_nn_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the nn_top testbench with Verilator and run it
# a $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

TOP=tb_nn_top
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f nn_top.f

"./$BUILD_DIR/V$TOP"
